// ==== files.f ====
muldiv_pkg.sv
muldiv_decode.sv
div_unit.sv
mul_unit.sv
muldiv_unit.sv
muldiv_sva.sv
tb_muldiv.sv

// ==== tb_muldiv.sv ====
// directed testbench for the multiply and divide block with reference model and compare tasks
`timescale 1ns/1ps

module tb_muldiv;

	logic clk;
	logic reset;
	logic start;
	logic [2:0] funct3;
	logic [muldiv_pkg::xlen-1:0] rs1;
	logic [muldiv_pkg::xlen-1:0] rs2;
	logic [muldiv_pkg::xlen-1:0] result;
	logic done;
	integer seed = 44787;

	muldiv_unit i_dut (
		.clk_i    (clk),
		.reset_i  (reset),
		.start_i  (start),
		.funct3_i (funct3),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.result_o (result),
		.done_o   (done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_on_error(input string msg);
		$display("Simulation FAILED");
		$fatal(1, "%s", msg);
	endtask

	task automatic check_result(input string name, input logic [muldiv_pkg::xlen-1:0] got,
			input logic [muldiv_pkg::xlen-1:0] exp);
		if (got !== exp)
			stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	task automatic check_op(input muldiv_pkg::muldiv_op_t got, input muldiv_pkg::muldiv_op_t exp);
		if (got !== exp)
			stop_on_error($sformatf("mismatch i_dut.op: got %h expected %h", got, exp));
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
			stop_on_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
	endtask

	// flags straight from the M-extension table
	function automatic muldiv_pkg::muldiv_op_t expected_op(input logic [2:0] f3);
		muldiv_pkg::muldiv_op_t op;
		op.is_div   = f3[2];
		op.want_alt = f3[2] ? f3[1] : (f3 != 3'b000);
		op.a_signed = (f3 == 3'b001) || (f3 == 3'b010) || (f3 == 3'b100) || (f3 == 3'b110);
		op.b_signed = (f3 == 3'b001) || (f3 == 3'b100) || (f3 == 3'b110);
		return op;
	endfunction

	function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		logic [63:0] p_ss;
		logic [63:0] p_su;
		logic [63:0] p_uu;
		logic signed [31:0] s_quo;
		logic signed [31:0] s_rem;
		logic overflow;
		p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // mod 2^64 is enough
		p_su = {{32{a[31]}}, a} * {32'b0, b};
		p_uu = {32'b0, a} * {32'b0, b};
		overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
		s_quo = a; // overflow quotient is the dividend
		s_rem = '0;
		if (b != 0 && !overflow) begin
			s_quo = $signed(a) / $signed(b); // truncates toward zero
			s_rem = $signed(a) % $signed(b);
		end
		case (f3)
			muldiv_pkg::funct3_mul:    return p_uu[31:0];
			muldiv_pkg::funct3_mulh:   return p_ss[63:32];
			muldiv_pkg::funct3_mulhsu: return p_su[63:32];
			muldiv_pkg::funct3_mulhu:  return p_uu[63:32];
			muldiv_pkg::funct3_div:    return (b == 0) ? 32'hffff_ffff : s_quo;
			muldiv_pkg::funct3_divu:   return (b == 0) ? 32'hffff_ffff : a / b;
			muldiv_pkg::funct3_rem:    return (b == 0) ? a : s_rem;
			default:                   return (b == 0) ? a : a % b;
		endcase
	endfunction

	task automatic run_op(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] exp_res;
		muldiv_pkg::muldiv_op_t exp_op;
		int cycles;
		int exp_cycles;
		exp_res = ref_result(f3, a, b);
		exp_op = expected_op(f3);
		if (!exp_op.is_div)
			exp_cycles = muldiv_pkg::mul_latency;
		else if (b == 0)
			exp_cycles = 1; // zero divisor answers right away
		else
			exp_cycles = muldiv_pkg::div_latency;
		@(posedge clk);
		start  <= 1'b1;
		funct3 <= f3;
		rs1    <= a;
		rs2    <= b;
		cycles = 0;
		@(negedge clk);
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (cycles > 2 * muldiv_pkg::div_latency)
				stop_on_error($sformatf("no done within %0d cycles for funct3 %0d", cycles, f3));
		end
		check_op(i_dut.op, exp_op);
		check_result("result_o", result, exp_res);
		check_count("latency", cycles, exp_cycles);
		@(posedge clk);
		start  <= 1'b0;
		funct3 <= f3 ^ 3'b100; // other unit selected now
		@(negedge clk);
		check_result("result_o held", result, exp_res);
	endtask

	task automatic test_multiply();
		logic [31:0] corners [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		int f;
		int i;
		int j;
		for (f = 0; f < 4; f++) begin
			for (i = 0; i < 5; i++)
				for (j = 0; j < 5; j++)
					run_op(f[2:0], corners[i], corners[j]);
			for (i = 0; i < 20; i++)
				run_op(f[2:0], $random(seed), $random(seed));
		end
	endtask

	task automatic test_divide();
		logic [31:0] a;
		logic [31:0] b;
		int f;
		int combo;
		int i;
		for (f = 4; f < 8; f++)
			for (combo = 0; combo < 4; combo++)
				for (i = 0; i < 5; i++) begin
					a = $random(seed);
					a[31] = combo[1];
					b = $unsigned($random(seed)) >> 1;
					b = (b >> ($unsigned($random(seed)) % 28)) | 32'h1; // spread of quotient sizes
					if (combo[0])
						b = -b;
					run_op(f[2:0], a, b);
				end
	endtask

	task automatic test_div_zero();
		int f;
		for (f = 4; f < 8; f++) begin
			run_op(f[2:0], $random(seed), 32'h0);
			run_op(f[2:0], 32'h8000_0000, 32'h0);
		end
	endtask

	task automatic test_overflow();
		run_op(muldiv_pkg::funct3_div, 32'h8000_0000, 32'hffff_ffff);
		run_op(muldiv_pkg::funct3_rem, 32'h8000_0000, 32'hffff_ffff);
	endtask

	task automatic test_abort();
		int i;
		@(posedge clk);
		start  <= 1'b1;
		funct3 <= muldiv_pkg::funct3_div;
		rs1    <= 32'd1000000;
		rs2    <= 32'd7;
		for (i = 0; i < muldiv_pkg::div_latency / 2; i++) begin
			@(negedge clk);
			if (done)
				stop_on_error("done pulsed while the aborted divide was still running");
		end
		@(posedge clk);
		start <= 1'b0; // abort halfway
		for (i = 0; i < 2 * muldiv_pkg::div_latency; i++) begin
			@(negedge clk);
			if (done)
				stop_on_error("done pulsed after the divide was aborted");
		end
		run_op(muldiv_pkg::funct3_div, 32'hffff_ff9c, 32'd7);
		run_op(muldiv_pkg::funct3_mulh, 32'hffff_ff9c, 32'd7);
	endtask

	initial begin
		reset  = 1'b1;
		start  = 1'b0;
		funct3 = 3'b000;
		rs1    = '0;
		rs2    = '0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		test_multiply();
		test_divide();
		test_div_zero();
		test_overflow();
		test_abort();
		repeat (2) @(posedge clk);
		if (i_dut.i_sva.fail_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== muldiv_sva.sv ====
// concurrent assertions on the start and done protocol of muldiv_unit, bound to it
`timescale 1ns/1ps

module muldiv_sva (
	input logic                        clk_i,
	input logic                        reset_i,
	input logic                        div_start_i,
	input logic                        mul_start_i,
	input logic                        div_done_i,
	input logic                        mul_done_i,
	input logic                        done_i,
	input logic [muldiv_pkg::xlen-1:0] divisor_i
);

	int fail_count = 0;

	done_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !done_i)
		else begin $error("done_o high while in reset"); fail_count++; end

	done_single_pulse: assert property (@(posedge clk_i) disable iff (reset_i) done_i |=> !done_i)
		else begin $error("done_o high for two cycles"); fail_count++; end

	// zero divisor answers early
	div_latency_exact: assert property (@(posedge clk_i) disable iff (reset_i)
		($rose(div_start_i) && divisor_i != '0) ##1 div_start_i [*(muldiv_pkg::div_latency-1)]
		|=> done_i)
		else begin $error("divide done not at div_latency"); fail_count++; end

	mul_latency_exact: assert property (@(posedge clk_i) disable iff (reset_i)
		$rose(mul_start_i) ##1 mul_start_i [*(muldiv_pkg::mul_latency-1)] |=> done_i)
		else begin $error("multiply done not at mul_latency"); fail_count++; end

	// a unit only answers to its own gated start
	one_unit_only: assert property (@(posedge clk_i) disable iff (reset_i)
		!(div_done_i && !$past(div_start_i)) && !(mul_done_i && !$past(mul_start_i)))
		else begin $error("done from a unit that was not started"); fail_count++; end

endmodule

bind muldiv_unit muldiv_sva i_sva (
	.clk_i       (clk_i),
	.reset_i     (reset_i),
	.div_start_i (div_start),
	.mul_start_i (mul_start),
	.div_done_i  (div_done),
	.mul_done_i  (mul_done),
	.done_i      (done_o),
	.divisor_i   (rs2_i)
);

// ==== muldiv_unit.sv ====
// M-extension execution block: decode, multiplier and divider, result select
`timescale 1ns/1ps

module muldiv_unit (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          start_i,
	input  logic [2:0]                    funct3_i,
	input  logic [muldiv_pkg::xlen-1:0]   rs1_i,
	input  logic [muldiv_pkg::xlen-1:0]   rs2_i,
	output logic [muldiv_pkg::xlen-1:0]   result_o,
	output logic                          done_o
);

	muldiv_pkg::muldiv_op_t op;

	logic div_start;
	logic mul_start;
	logic div_done;
	logic mul_done;
	logic res_sel_r; // unit of the last done
	logic sel_div;
	logic [muldiv_pkg::xlen-1:0] div_result;
	logic [muldiv_pkg::xlen-1:0] mul_result;

	muldiv_decode i_decode (
		.funct3_i (funct3_i),
		.op_o     (op)
	);

	assign div_start = start_i & op.is_div; // only one unit runs
	assign mul_start = start_i & ~op.is_div;

	div_unit i_div (
		.clk_i      (clk_i),
		.reset_i    (reset_i),
		.start_i    (div_start),
		.op_i       (op),
		.dividend_i (rs1_i),
		.divisor_i  (rs2_i),
		.result_o   (div_result),
		.done_o     (div_done)
	);

	mul_unit i_mul (
		.clk_i          (clk_i),
		.reset_i        (reset_i),
		.start_i        (mul_start),
		.op_i           (op),
		.multiplicand_i (rs1_i),
		.multiplier_i   (rs2_i),
		.result_o       (mul_result),
		.done_o         (mul_done)
	);

	assign done_o = op.is_div ? div_done : mul_done;

	// keep result stable after done even if funct3 moves on
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			res_sel_r <= 1'b0;
		end else if (done_o) begin
			res_sel_r <= op.is_div;
		end
	end

	assign sel_div  = done_o ? op.is_div : res_sel_r;
	assign result_o = sel_div ? div_result : mul_result;

endmodule

// ==== mul_unit.sv ====
// iterative 32x32 multiplier, 8 multiplier bits per cycle, low or high word out
`timescale 1ns/1ps

module mul_unit (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          start_i,
	input  muldiv_pkg::muldiv_op_t        op_i,
	input  logic [muldiv_pkg::xlen-1:0]   multiplicand_i,
	input  logic [muldiv_pkg::xlen-1:0]   multiplier_i,
	output logic [muldiv_pkg::xlen-1:0]   result_o,
	output logic                          done_o
);

	// one-hot step, bit 0 idle and load, top bit sign fix
	logic [muldiv_pkg::mul_latency-1:0] step_r;
	logic hold_r;
	logic done_r;

	logic [2*muldiv_pkg::xlen-1:0] mcand_r; // shifts left a byte per step
	logic [2*muldiv_pkg::xlen-1:0] prod_r;
	logic [muldiv_pkg::xlen-1:0]   mplier_r;
	logic neg_r;

	logic sign_a;
	logic sign_b;
	logic load;
	logic accumulate;
	logic final_step;
	logic [muldiv_pkg::xlen-1:0]   a_mag;
	logic [muldiv_pkg::xlen-1:0]   b_mag;
	logic [2*muldiv_pkg::xlen-1:0] partial;
	logic [2*muldiv_pkg::xlen-1:0] prod_signed;

	assign sign_a = op_i.a_signed & multiplicand_i[muldiv_pkg::xlen-1];
	assign sign_b = op_i.b_signed & multiplier_i[muldiv_pkg::xlen-1];
	assign a_mag  = sign_a ? -multiplicand_i : multiplicand_i;
	assign b_mag  = sign_b ? -multiplier_i : multiplier_i;

	assign load       = start_i & step_r[0] & ~hold_r;
	assign final_step = start_i & step_r[muldiv_pkg::mul_latency-1];
	assign accumulate = start_i & ~step_r[0] & ~step_r[muldiv_pkg::mul_latency-1];

	assign partial     = mcand_r * {{(2*muldiv_pkg::xlen-8){1'b0}}, mplier_r[7:0]};
	assign prod_signed = neg_r ? -prod_r : prod_r;

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			step_r <= {{(muldiv_pkg::mul_latency-1){1'b0}}, 1'b1};
			hold_r <= 1'b0;
			done_r <= 1'b0;
		end else begin
			done_r <= final_step;
			if (!start_i) begin
				step_r <= {{(muldiv_pkg::mul_latency-1){1'b0}}, 1'b1};
				hold_r <= 1'b0;
			end else if (final_step) begin
				step_r <= {{(muldiv_pkg::mul_latency-1){1'b0}}, 1'b1};
				hold_r <= 1'b1; // no restart until start drops
			end else if (load || accumulate) begin
				step_r <= step_r << 1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			mcand_r  <= {{muldiv_pkg::xlen{1'b0}}, a_mag};
			mplier_r <= b_mag;
			prod_r   <= '0;
			neg_r    <= sign_a ^ sign_b;
		end else if (accumulate) begin
			prod_r   <= prod_r + partial;
			mcand_r  <= mcand_r << 8;
			mplier_r <= mplier_r >> 8;
		end else if (final_step) begin
			result_o <= op_i.want_alt ? prod_signed[2*muldiv_pkg::xlen-1:muldiv_pkg::xlen]
				: prod_signed[muldiv_pkg::xlen-1:0];
		end
	end

	assign done_o = done_r;

endmodule

// ==== div_unit.sv ====
// restoring radix-2 divider for DIV, DIVU, REM and REMU with sign correction
`timescale 1ns/1ps

module div_unit (
	input  logic                          clk_i,
	input  logic                          reset_i,
	input  logic                          start_i,
	input  muldiv_pkg::muldiv_op_t        op_i,
	input  logic [muldiv_pkg::xlen-1:0]   dividend_i,
	input  logic [muldiv_pkg::xlen-1:0]   divisor_i,
	output logic [muldiv_pkg::xlen-1:0]   result_o,
	output logic                          done_o
);

	// one-hot step, bit 0 idle and load, top bit sign fix
	logic [muldiv_pkg::div_latency-1:0] cycle_r;
	logic hold_r; // finished, waiting for start to drop
	logic done_r;

	logic [muldiv_pkg::xlen-1:0] quo_r; // dividend shifts out, quotient shifts in
	logic [muldiv_pkg::xlen-1:0] rem_r;
	logic [muldiv_pkg::xlen-1:0] dvs_r;
	logic neg_quo_r;
	logic neg_rem_r;

	logic sign_a;
	logic sign_b;
	logic divisor_zero;
	logic load;
	logic iterate;
	logic final_step;
	logic [muldiv_pkg::xlen-1:0] dividend_mag;
	logic [muldiv_pkg::xlen-1:0] divisor_mag;
	logic [muldiv_pkg::xlen:0]   shifted;
	logic [muldiv_pkg::xlen+1:0] trial;
	logic [muldiv_pkg::xlen-1:0] quo_fix;
	logic [muldiv_pkg::xlen-1:0] rem_fix;

	assign sign_a       = op_i.a_signed & dividend_i[muldiv_pkg::xlen-1];
	assign sign_b       = op_i.b_signed & divisor_i[muldiv_pkg::xlen-1];
	assign divisor_zero = (divisor_i == '0);
	assign dividend_mag = sign_a ? -dividend_i : dividend_i;
	assign divisor_mag  = sign_b ? -divisor_i : divisor_i;

	assign load       = start_i & cycle_r[0] & ~hold_r;
	assign final_step = start_i & cycle_r[muldiv_pkg::div_latency-1];
	assign iterate    = start_i & ~cycle_r[0] & ~cycle_r[muldiv_pkg::div_latency-1];

	// partial remainder gets the next dividend bit, then trial subtract
	assign shifted = {rem_r, quo_r[muldiv_pkg::xlen-1]};
	assign trial   = {1'b0, shifted} - {2'b00, dvs_r};

	assign quo_fix = neg_quo_r ? -quo_r : quo_r;
	assign rem_fix = neg_rem_r ? -rem_r : rem_r; // remainder follows dividend

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cycle_r <= {{(muldiv_pkg::div_latency-1){1'b0}}, 1'b1};
			hold_r  <= 1'b0;
			done_r  <= 1'b0;
		end else begin
			done_r <= 1'b0;
			if (!start_i) begin // idle or abort
				cycle_r <= {{(muldiv_pkg::div_latency-1){1'b0}}, 1'b1};
				hold_r  <= 1'b0;
			end else if (load) begin
				if (divisor_zero) begin
					hold_r <= 1'b1;
					done_r <= 1'b1;
				end else begin
					cycle_r <= cycle_r << 1;
				end
			end else if (final_step) begin
				cycle_r <= {{(muldiv_pkg::div_latency-1){1'b0}}, 1'b1};
				hold_r  <= 1'b1;
				done_r  <= 1'b1;
			end else if (iterate) begin
				cycle_r <= cycle_r << 1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			quo_r     <= dividend_mag;
			rem_r     <= '0;
			dvs_r     <= divisor_mag;
			neg_quo_r <= sign_a ^ sign_b;
			neg_rem_r <= sign_a;
			if (divisor_zero) begin
				// riscv: quotient all ones, remainder is the dividend
				result_o <= op_i.want_alt ? dividend_i : '1;
			end
		end else if (iterate) begin
			if (trial[muldiv_pkg::xlen+1]) begin // negative, restore
				rem_r <= shifted[muldiv_pkg::xlen-1:0];
				quo_r <= {quo_r[muldiv_pkg::xlen-2:0], 1'b0};
			end else begin
				rem_r <= trial[muldiv_pkg::xlen-1:0];
				quo_r <= {quo_r[muldiv_pkg::xlen-2:0], 1'b1};
			end
		end else if (final_step) begin
			result_o <= op_i.want_alt ? rem_fix : quo_fix;
		end
	end

	assign done_o = done_r;

endmodule

// ==== muldiv_decode.sv ====
// funct3 to decoded operation flags for multiply and divide
`timescale 1ns/1ps

module muldiv_decode (
	input  logic [2:0]             funct3_i,
	output muldiv_pkg::muldiv_op_t op_o
);

	always_comb begin
		op_o = '0;
		case (funct3_i)
			muldiv_pkg::funct3_mul: begin
				op_o.is_div   = 1'b0; // low word is sign independent
				op_o.a_signed = 1'b0;
				op_o.b_signed = 1'b0;
				op_o.want_alt = 1'b0;
			end
			muldiv_pkg::funct3_mulh: begin
				op_o.a_signed = 1'b1;
				op_o.b_signed = 1'b1;
				op_o.want_alt = 1'b1;
			end
			muldiv_pkg::funct3_mulhsu: begin
				op_o.a_signed = 1'b1;
				op_o.b_signed = 1'b0;
				op_o.want_alt = 1'b1;
			end
			muldiv_pkg::funct3_mulhu: begin
				op_o.want_alt = 1'b1;
			end
			muldiv_pkg::funct3_div: begin
				op_o.is_div   = 1'b1;
				op_o.a_signed = 1'b1;
				op_o.b_signed = 1'b1;
			end
			muldiv_pkg::funct3_divu: begin
				op_o.is_div   = 1'b1;
			end
			muldiv_pkg::funct3_rem: begin
				op_o.is_div   = 1'b1;
				op_o.a_signed = 1'b1;
				op_o.b_signed = 1'b1;
				op_o.want_alt = 1'b1;
			end
			default: begin // remu
				op_o.is_div   = 1'b1;
				op_o.want_alt = 1'b1;
			end
		endcase
	end

endmodule

// ==== muldiv_pkg.sv ====
// data width, funct3 encodings, decoded operation struct and latencies of the M-extension block
package muldiv_pkg;

	localparam int xlen = 32;

	// funct3 of the OP opcode with funct7 = 0000001
	localparam logic [2:0] funct3_mul    = 3'b000;
	localparam logic [2:0] funct3_mulh   = 3'b001;
	localparam logic [2:0] funct3_mulhsu = 3'b010;
	localparam logic [2:0] funct3_mulhu  = 3'b011;
	localparam logic [2:0] funct3_div    = 3'b100;
	localparam logic [2:0] funct3_divu   = 3'b101;
	localparam logic [2:0] funct3_rem    = 3'b110;
	localparam logic [2:0] funct3_remu   = 3'b111;

	typedef struct packed {
		logic is_div;   // divider instead of multiplier
		logic a_signed; // rs1 is two's complement
		logic b_signed; // rs2 is two's complement
		logic want_alt; // high product word or remainder
	} muldiv_op_t;

	// first start cycle to done pulse
	// divider: load, 32 iterations, sign fix
	localparam int div_latency = 34;
	// multiplier: load, 4 byte steps, sign fix
	localparam int mul_latency = 6;

endpackage
